// ==== bench/rob_asserts.sv ====
////////////////////////////////////////////////////////////
// Checks on the response release logic attached by bind
// Parked slots are tracked locally from the park and free strobes
// The ID FIFO empty flags come from the request tracker beside it
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_asserts (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input rob_pkg::release_state_e    state_i,
  input logic                       out_valid_i,
  input logic                       out_ready_i,
  input rob_pkg::rsp_t              out_rsp_i,
  input logic                       pop_i,
  input rob_pkg::id_t               pop_id_i,
  input logic [rob_pkg::NumIds-1:0] id_empty_i,
  input logic                       park_i,
  input rob_pkg::rob_idx_t          park_idx_i,
  input logic                       free_i,
  input rob_pkg::rob_idx_t          free_idx_i
);

  logic [rob_pkg::RobSize-1:0] parked_q;
  // Number of assertion failures so far
  int unsigned                 fail_cnt = 0;

  // Slots that hold a parked response right now
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      parked_q <= '0;
    end else begin
      if (park_i) parked_q[park_idx_i] <= 1'b1;
      if (free_i) parked_q[free_idx_i] <= 1'b0;
    end
  end

  a_release_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_i == rob_pkg::Releasing && out_valid_i && !out_ready_i) |=>
      (out_valid_i && $stable(out_rsp_i)))
    else begin
      fail_cnt++;
      $error("Released response changed before it was accepted");
    end

  a_park_empty_slot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    park_i |-> !parked_q[park_idx_i])
    else begin
      fail_cnt++;
      $error("Response parked into a slot that already holds one");
    end

  // A pop must always find an outstanding entry of its ID
  a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !id_empty_i[pop_id_i])
    else begin
      fail_cnt++;
      $error("Status entry popped from an ID with nothing outstanding");
    end

endmodule

bind rob_rsp_release rob_asserts rob_asserts_i (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .state_i      (state_q),
  .out_valid_i  (rsp_valid_o),
  .out_ready_i  (rsp_ready_i),
  .out_rsp_i    (rsp_o),
  .pop_i        (status.pop),
  .pop_id_i     (status.pop_id),
  .id_empty_i   (rob_req_tracker_i.fifo_empty),
  .park_i       (slot.park),
  .park_idx_i   (slot.park_idx),
  .free_i       (slot.free),
  .free_idx_i   (slot.free_idx)
);

// ==== bench/rob_stim.txt ====
// First word: request count N; then N rows of id dest data
// Then N rows of return order: request index, requests accepted before it is returned
13
0 0 a0
0 0 a1
0 0 a2
0 0 a3
0 0 a4
1 0 b0
1 1 b1
1 1 b2
1 1 b3
2 0 c0
2 1 c1
2 1 c2
2 1 c3
3 0 d0
3 2 d1
3 2 d2
3 2 d3
1 2 e0
1 2 e1
00 04
01 05
02 05
03 05
04 05
05 10
07 10
06 10
08 11
0c 11
0b 11
0a 11
09 11
0f 11
0d 11
10 11
0e 11
11 12
12 13

// ==== bench/rob_tb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the reorder buffer top level
// Stimulus comes from bench/rob_stim.txt relative to the project root
// The network model returns responses in the file's order only
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_tb;

  localparam int unsigned ClkPeriod  = 100;
  localparam int unsigned HoldCycles = 4;
  localparam int unsigned MaxReq     = 32;

  logic              clk_i;
  logic              rst_n_i;
  logic              ax_valid_i;
  rob_pkg::id_t      ax_id_i;
  rob_pkg::dest_t    ax_dest_i;
  logic              ax_ready_o;
  logic              ax_valid_o;
  logic              ax_ready_i;
  logic              ax_rob_req_o;
  rob_pkg::rob_idx_t ax_rob_idx_o;
  logic              rsp_valid_i;
  rob_pkg::rsp_t     rsp_i;
  logic              rsp_rob_req_i;
  rob_pkg::rob_idx_t rsp_rob_idx_i;
  logic              rsp_ready_o;
  logic              rsp_valid_o;
  rob_pkg::rsp_t     rsp_o;
  logic              rsp_ready_i;

  // Stimulus as read from the file and then split into requests and returns
  logic [7:0]        stim_mem [0:255];
  int unsigned       n_req;
  rob_pkg::id_t      req_id [MaxReq];
  rob_pkg::dest_t    req_dest [MaxReq];
  logic [7:0]        req_data [MaxReq];
  int unsigned       ret_req [MaxReq];
  int unsigned       ret_gate [MaxReq];
  // Tag of each accepted request that the network echoes back
  logic              acc_tag [MaxReq];
  rob_pkg::rob_idx_t acc_idx [MaxReq];
  // Tag and slot that the reference model gives each accepted request
  logic              model_tag [MaxReq];
  rob_pkg::rob_idx_t model_idx [MaxReq];
  // Reference model keeps accepted request indices per ID in acceptance order
  int unsigned       ref_q [rob_pkg::NumIds][$];
  int unsigned       out_cnt [rob_pkg::NumIds];
  logic              reorder [rob_pkg::NumIds];
  rob_pkg::dest_t    prev_dest [rob_pkg::NumIds];
  logic [rob_pkg::RobSize-1:0] slot_used;
  int unsigned       value_errs;
  int unsigned       other_errs;
  int unsigned       fifo_block;
  int unsigned       slot_block;

  rob_top rob_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  task automatic check_rsp(input string name, input rob_pkg::rsp_t exp, input rob_pkg::rsp_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Error: %s expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_tag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errs++;
      $display("Error: %s expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_idx(input string name, input rob_pkg::rob_idx_t exp,
                           input rob_pkg::rob_idx_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Error: %s expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  // The store hands out the lowest slot that no request holds
  function automatic rob_pkg::rob_idx_t lowest_free(input logic [rob_pkg::RobSize-1:0] used);
    for (int i = 0; i < rob_pkg::RobSize; i++) begin
      if (!used[i]) return rob_pkg::rob_idx_t'(i);
    end
    return '0;
  endfunction

  // Watchdog sized from the number of requests in the file
  initial begin
    wait (n_req != 0);
    repeat (n_req * 40 + 200) @(posedge clk_i);
    $display("Timed out before all responses came out of the DUT");
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus, network model and checks run once per cycle
  ////////////////////////////////////////////////////////////

  initial begin
    int unsigned       req_ptr;
    int unsigned       ret_ptr;
    int unsigned       hold;
    int unsigned       out_total;
    int unsigned       ridx;
    logic              exp_tag;
    logic              exp_valid;
    logic              acc;
    logic              rsp_taken;
    rob_pkg::id_t      oid;
    rob_pkg::rsp_t     exp_rsp;
    rob_pkg::rob_idx_t exp_idx;
    void'($urandom(32'hf1fb_909f));
    {rst_n_i, ax_valid_i, ax_id_i, ax_dest_i, ax_ready_i} = '0;
    {rsp_valid_i, rsp_i, rsp_rob_req_i, rsp_rob_idx_i, rsp_ready_i} = '0;
    {req_ptr, ret_ptr, hold, out_total, value_errs, other_errs} = '0;
    {fifo_block, slot_block, slot_used, rsp_taken} = '0;
    for (int i = 0; i < rob_pkg::NumIds; i++) begin
      out_cnt[i]   = 0;
      reorder[i]   = 1'b0;
      prev_dest[i] = '0;
    end
    $readmemh("bench/rob_stim.txt", stim_mem);
    for (int i = 0; i < stim_mem[0]; i++) begin
      req_id[i]   = rob_pkg::id_t'(stim_mem[1 + 3 * i]);
      req_dest[i] = rob_pkg::dest_t'(stim_mem[2 + 3 * i]);
      req_data[i] = stim_mem[3 + 3 * i];
      ret_req[i]  = stim_mem[1 + 3 * stim_mem[0] + 2 * i];
      ret_gate[i] = stim_mem[2 + 3 * stim_mem[0] + 2 * i];
    end
    n_req = stim_mem[0];

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #(ClkPeriod / 2 - 10);
    check_tag("ax_valid_o", 1'b0, ax_valid_o);
    check_tag("rsp_valid_o", 1'b0, rsp_valid_o);

    while (out_total < n_req) begin
      @(negedge clk_i);
      ax_ready_i  = ($urandom_range(3) != 0);
      rsp_ready_i = ($urandom_range(3) != 0);
      if (rsp_taken) rsp_valid_i = 1'b0;
      ax_valid_i = (req_ptr < n_req);
      if (ax_valid_i) begin
        ax_id_i   = req_id[req_ptr];
        ax_dest_i = req_dest[req_ptr];
      end
      // A response goes out once its request and its gate are both met
      if (!rsp_valid_i && ret_ptr < n_req && req_ptr >= ret_gate[ret_ptr] &&
          req_ptr > ret_req[ret_ptr]) begin
        if (hold == HoldCycles) begin
          ridx          = ret_req[ret_ptr];
          rsp_valid_i   = 1'b1;
          rsp_i         = '{id: req_id[ridx], data: req_data[ridx]};
          rsp_rob_req_i = acc_tag[ridx];
          rsp_rob_idx_i = acc_idx[ridx];
          hold          = 0;
        end else begin
          hold++;
        end
      end
      #(ClkPeriod / 2 - 10);

      // Tag rule and grant follow the model state before this edge
      exp_tag   = reorder[ax_id_i] ||
                  (out_cnt[ax_id_i] != 0 && prev_dest[ax_id_i] != ax_dest_i);
      exp_valid = ax_valid_i && out_cnt[ax_id_i] < rob_pkg::MaxTxnsPerId &&
                  (!exp_tag || !(&slot_used));
      exp_idx   = lowest_free(slot_used);
      check_tag("ax_valid_o", exp_valid, ax_valid_o);
      check_tag("ax_ready_o", exp_valid && ax_ready_i, ax_ready_o);
      if (exp_valid) check_tag("ax_rob_req_o", exp_tag, ax_rob_req_o);
      if (exp_valid && exp_tag) check_idx("ax_rob_idx_o", exp_idx, ax_rob_idx_o);
      if (ax_valid_i && out_cnt[ax_id_i] == rob_pkg::MaxTxnsPerId) fifo_block++;
      if (ax_valid_i && out_cnt[ax_id_i] < rob_pkg::MaxTxnsPerId && exp_tag && &slot_used) begin
        slot_block++;
      end
      acc       = exp_valid && ax_ready_i;
      rsp_taken = rsp_valid_i && rsp_ready_o;
      if (rsp_taken) ret_ptr++;

      // Every response must match the oldest outstanding request of its ID
      if (rsp_valid_o && rsp_ready_i) begin
        oid = rsp_o.id;
        if (ref_q[oid].size() == 0) begin
          other_errs++;
          $display("A response for ID %0d came out with none outstanding", oid);
        end else begin
          ridx    = ref_q[oid].pop_front();
          exp_rsp = '{id: req_id[ridx], data: req_data[ridx]};
          check_rsp("rsp_o", exp_rsp, rsp_o);
          if (model_tag[ridx]) slot_used[model_idx[ridx]] = 1'b0;
          out_cnt[oid]--;
          if (out_cnt[oid] == 0 && !(acc && ax_id_i == oid)) reorder[oid] = 1'b0;
          out_total++;
        end
      end
      if (acc) begin
        acc_tag[req_ptr]   = ax_rob_req_o;
        acc_idx[req_ptr]   = ax_rob_idx_o;
        model_tag[req_ptr] = exp_tag;
        model_idx[req_ptr] = exp_idx;
        if (exp_tag) slot_used[exp_idx] = 1'b1;
        if (exp_tag) reorder[ax_id_i] = 1'b1;
        ref_q[ax_id_i].push_back(req_ptr);
        out_cnt[ax_id_i]++;
        prev_dest[ax_id_i] = ax_dest_i;
        req_ptr++;
      end
    end

    // Nothing more may come out once every request was answered
    @(negedge clk_i);
    ax_valid_i  = 1'b0;
    rsp_valid_i = 1'b0;
    repeat (10) begin
      @(negedge clk_i);
      #(ClkPeriod / 2 - 10);
      check_tag("rsp_valid_o", 1'b0, rsp_valid_o);
    end
    if (fifo_block == 0) begin
      other_errs++;
      $display("No request was ever held back by a full ID FIFO");
    end
    if (slot_block == 0) begin
      other_errs++;
      $display("No tagged request was ever held back by a full buffer");
    end
    // Assertion failures in the release logic count as other errors
    other_errs += rob_top_i.rob_rsp_release_i.rob_asserts_i.fail_cnt;
    $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== hw/rob_id_fifo.sv ====
////////////////////////////////////////////////////////////
// Status FIFO for one transaction ID
// A push when full or a pop when empty is ignored
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_id_fifo (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                push_i,
  input  logic                pop_i,
  input  rob_pkg::id_entry_t  entry_i,
  output rob_pkg::id_entry_t  entry_o,
  output logic                full_o,
  output logic                empty_o,
  output rob_pkg::fifo_cnt_t  count_o
);

  rob_pkg::id_entry_t mem_q [rob_pkg::MaxTxnsPerId];
  rob_pkg::fifo_ptr_t wr_ptr_q;
  rob_pkg::fifo_ptr_t rd_ptr_q;
  rob_pkg::fifo_cnt_t count_q;
  logic               do_push;
  logic               do_pop;

  assign full_o  = (count_q == rob_pkg::fifo_cnt_t'(rob_pkg::MaxTxnsPerId));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  // Head entry is shown without a clock
  assign entry_o = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop leave the count unchanged
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= entry_i;
  end

endmodule

// ==== hw/rob_if.sv ====
////////////////////////////////////////////////////////////
// Internal links of the reorder buffer
// All signals are combinational requests or answers within one cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

// Status table access from the response side
interface rob_status_if;
  // Head removal for one ID, single-cycle strobe
  logic             pop;
  rob_pkg::id_t     pop_id;
  rob_pkg::id_t     peek_id;
  // Head entry of pop_id
  logic             head_rob_req;
  rob_pkg::rob_idx_t head_rob_idx;
  // Head entry of peek_id, valid only when it is tagged
  logic             peek_valid;
  rob_pkg::rob_idx_t peek_rob_idx;

  modport tracker (
    input  pop, pop_id, peek_id,
    output head_rob_req, head_rob_idx, peek_valid, peek_rob_idx
  );
  modport releaser (
    output pop, pop_id, peek_id,
    input  head_rob_req, head_rob_idx, peek_valid, peek_rob_idx
  );
endinterface

// Slot store access from the response side
interface rob_slot_if;
  logic              park;
  rob_pkg::rob_idx_t park_idx;
  rob_pkg::rsp_t     park_rsp;
  logic              free;
  rob_pkg::rob_idx_t free_idx;
  // Unclocked read port
  rob_pkg::rob_idx_t look_idx;
  logic              look_valid;
  rob_pkg::rsp_t     look_rsp;

  modport store (
    input  park, park_idx, park_rsp, free, free_idx, look_idx,
    output look_valid, look_rsp
  );
  modport releaser (
    output park, park_idx, park_rsp, free, free_idx, look_idx,
    input  look_valid, look_rsp
  );
endinterface

// ==== hw/rob_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared sizes and types of the reorder buffer
// Every response is a single beat, so one slot holds one response
// Slot and pointer widths must track the counts below by hand
////////////////////////////////////////////////////////////
package rob_pkg;

  // Transaction IDs and destinations
  localparam int unsigned NumIds    = 4;
  localparam int unsigned IdWidth   = 2;
  localparam int unsigned DestWidth = 2;

  // Reorder slots
  localparam int unsigned RobSize     = 8;
  localparam int unsigned RobIdxWidth = 3;

  // Depth of each per-ID status FIFO, with its pointer and counter widths
  localparam int unsigned MaxTxnsPerId = 4;
  localparam int unsigned FifoPtrWidth = 2;
  localparam int unsigned FifoCntWidth = 3;

  // Response payload
  localparam int unsigned DataWidth = 8;

  typedef logic [IdWidth-1:0]      id_t;
  typedef logic [DestWidth-1:0]    dest_t;
  typedef logic [RobIdxWidth-1:0]  rob_idx_t;
  typedef logic [FifoPtrWidth-1:0] fifo_ptr_t;
  typedef logic [FifoCntWidth-1:0] fifo_cnt_t;

  // A response carries its ID so that it can be routed back by the requester
  typedef struct packed {
    id_t                  id;
    logic [DataWidth-1:0] data;
  } rsp_t;

  // One status entry per outstanding request
  typedef struct packed {
    logic     rob_req;
    rob_idx_t rob_idx;
  } id_entry_t;

  // Parking stores or forwards input, releasing drains the buffer
  typedef enum logic {
    Parking   = 1'b0,
    Releasing = 1'b1
  } release_state_e;

endpackage

// ==== hw/rob_req_tracker.sv ====
////////////////////////////////////////////////////////////
// Request side of the reorder buffer
// Purely combinational grant, a request is taken on ax_ready_i
// Tagged requests also need a free slot in the store
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_req_tracker (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                ax_valid_i,
  input  rob_pkg::id_t        ax_id_i,
  input  rob_pkg::dest_t      ax_dest_i,
  input  logic                ax_ready_i,
  output logic                ax_valid_o,
  output logic                ax_ready_o,
  output logic                ax_rob_req_o,
  output rob_pkg::rob_idx_t   ax_rob_idx_o,
  input  logic                has_free_i,
  input  rob_pkg::rob_idx_t   free_idx_i,
  output logic                alloc_o,
  rob_status_if.tracker       status
);

  logic [rob_pkg::NumIds-1:0]                 fifo_push;
  logic [rob_pkg::NumIds-1:0]                 fifo_pop;
  logic [rob_pkg::NumIds-1:0]                 fifo_full;
  logic [rob_pkg::NumIds-1:0]                 fifo_empty;
  rob_pkg::id_entry_t                         fifo_head [rob_pkg::NumIds];
  rob_pkg::fifo_cnt_t                         fifo_count [rob_pkg::NumIds];
  rob_pkg::id_entry_t                         push_entry;
  // Sticky reorder flag and last destination of every ID
  logic [rob_pkg::NumIds-1:0]                 reorder_q;
  rob_pkg::dest_t [rob_pkg::NumIds-1:0]       prev_dest_q;
  logic                                       ax_push;

  ////////////////////////////////////////////////////////////
  // Tag decision and grant
  ////////////////////////////////////////////////////////////

  // A new destination behind outstanding requests may overtake them
  assign ax_rob_req_o = reorder_q[ax_id_i] ||
                        ((fifo_count[ax_id_i] != '0) && (prev_dest_q[ax_id_i] != ax_dest_i));
  assign ax_rob_idx_o = free_idx_i;

  assign ax_valid_o = ax_valid_i && !fifo_full[ax_id_i] && (!ax_rob_req_o || has_free_i);
  assign ax_ready_o = ax_valid_o && ax_ready_i;
  assign ax_push    = ax_ready_o;
  // Only a tagged request claims the slot offered by the store
  assign alloc_o    = ax_push && ax_rob_req_o;

  assign push_entry = '{rob_req: ax_rob_req_o, rob_idx: free_idx_i};

  // Head entries seen by the response side
  assign status.head_rob_req = fifo_head[status.pop_id].rob_req;
  assign status.head_rob_idx = fifo_head[status.pop_id].rob_idx;
  assign status.peek_valid   = !fifo_empty[status.peek_id] && fifo_head[status.peek_id].rob_req;
  assign status.peek_rob_idx = fifo_head[status.peek_id].rob_idx;

  ////////////////////////////////////////////////////////////
  // Status FIFOs, one per ID
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < rob_pkg::NumIds; g++) begin : gen_id_fifo
    assign fifo_push[g] = ax_push && (ax_id_i == rob_pkg::id_t'(g));
    assign fifo_pop[g]  = status.pop && (status.pop_id == rob_pkg::id_t'(g));

    rob_id_fifo rob_id_fifo_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .push_i  (fifo_push[g]),
      .pop_i   (fifo_pop[g]),
      .entry_i (push_entry),
      .entry_o (fifo_head[g]),
      .full_o  (fifo_full[g]),
      .empty_o (fifo_empty[g]),
      .count_o (fifo_count[g])
    );
  end

  // The flag drops with the last outstanding entry, unless a new one arrives
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      reorder_q   <= '0;
      prev_dest_q <= '0;
    end else begin
      for (int i = 0; i < rob_pkg::NumIds; i++) begin
        if (fifo_push[i]) begin
          prev_dest_q[i] <= ax_dest_i;
          if (ax_rob_req_o) reorder_q[i] <= 1'b1;
        end else if (fifo_pop[i] && (fifo_count[i] == rob_pkg::fifo_cnt_t'(1))) begin
          reorder_q[i] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hw/rob_rsp_release.sv ====
////////////////////////////////////////////////////////////
// Response side of the reorder buffer
// Forwards in-order responses, parks the others, then releases them
// Only the ID of the last accepted response is watched for release
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_rsp_release (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              rsp_valid_i,
  input  rob_pkg::rsp_t     rsp_i,
  input  logic              rsp_rob_req_i,
  input  rob_pkg::rob_idx_t rsp_rob_idx_i,
  output logic              rsp_ready_o,
  output logic              rsp_valid_o,
  output rob_pkg::rsp_t     rsp_o,
  input  logic              rsp_ready_i,
  rob_status_if.releaser    status,
  rob_slot_if.releaser      slot
);

  rob_pkg::release_state_e state_q;
  rob_pkg::release_state_e state_d;
  rob_pkg::id_t            peek_id_q;
  logic                    out_valid_q;
  logic                    out_valid_d;
  logic                    release_ready;
  logic                    in_order;

  // The head of the peeked ID already waits in the store
  assign release_ready = status.peek_valid && slot.look_valid;
  // A tagged response matching the head of its ID needs no parking
  assign in_order = status.head_rob_req && (rsp_rob_idx_i == status.head_rob_idx);

  assign status.peek_id = peek_id_q;
  assign slot.look_idx  = status.peek_rob_idx;
  assign slot.park_idx  = rsp_rob_idx_i;
  assign slot.park_rsp  = rsp_i;

  // Released data comes straight from the store
  assign rsp_o = (state_q == rob_pkg::Releasing) ? slot.look_rsp : rsp_i;

  ////////////////////////////////////////////////////////////
  // Forward, park or release
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    out_valid_d   = 1'b0;
    rsp_valid_o   = 1'b0;
    rsp_ready_o   = 1'b0;
    status.pop    = 1'b0;
    status.pop_id = rsp_i.id;
    slot.park     = 1'b0;
    slot.free     = 1'b0;
    slot.free_idx = rsp_rob_idx_i;

    case (state_q)
      rob_pkg::Parking: begin
        rsp_ready_o = rsp_ready_i;
        if (release_ready) begin
          // Draining has priority and the input is held off meanwhile
          state_d     = rob_pkg::Releasing;
          rsp_ready_o = 1'b0;
        end else if (rsp_valid_i) begin
          if (!rsp_rob_req_i || in_order) begin
            rsp_valid_o = 1'b1;
            status.pop  = rsp_ready_i;
            // An in-order tagged response gives its reserved slot back
            slot.free   = rsp_ready_i && rsp_rob_req_i;
          end else begin
            rsp_ready_o = 1'b1;
            slot.park   = 1'b1;
          end
        end
      end

      rob_pkg::Releasing: begin
        status.pop_id = peek_id_q;
        slot.free_idx = status.peek_rob_idx;
        if (release_ready) begin
          // Valid is raised one cycle after the entry was found
          out_valid_d = 1'b1;
          rsp_valid_o = out_valid_q;
          if (out_valid_q && rsp_ready_i) begin
            slot.free   = 1'b1;
            status.pop  = 1'b1;
            out_valid_d = 1'b0;
          end
        end else begin
          state_d = rob_pkg::Parking;
        end
      end

      default: begin
        state_d = rob_pkg::Parking;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= rob_pkg::Parking;
      out_valid_q <= 1'b0;
      peek_id_q   <= '0;
    end else begin
      state_q     <= state_d;
      out_valid_q <= out_valid_d;
      // Follow the ID of every accepted input response
      if (rsp_valid_i && rsp_ready_o) peek_id_q <= rsp_i.id;
    end
  end

endmodule

// ==== hw/rob_slot_store.sv ====
////////////////////////////////////////////////////////////
// Slot store holding parked single-beat responses
// The response side must not park into a valid slot
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_slot_store (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              alloc_i,
  output logic              has_free_o,
  output rob_pkg::rob_idx_t free_idx_o,
  rob_slot_if.store         slot
);

  // Allocated means reserved by a request, valid means a response sits there
  logic [rob_pkg::RobSize-1:0] alloc_q;
  logic [rob_pkg::RobSize-1:0] valid_q;
  rob_pkg::rsp_t               rsp_q [rob_pkg::RobSize];

  // Priority search for the lowest unallocated slot
  always_comb begin
    has_free_o = 1'b0;
    free_idx_o = '0;
    for (int i = rob_pkg::RobSize - 1; i >= 0; i--) begin
      if (!alloc_q[i]) begin
        has_free_o = 1'b1;
        free_idx_o = rob_pkg::rob_idx_t'(i);
      end
    end
  end

  // Unclocked read for the release check and the released payload
  assign slot.look_valid = valid_q[slot.look_idx];
  assign slot.look_rsp   = rsp_q[slot.look_idx];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alloc_q <= '0;
      valid_q <= '0;
    end else begin
      if (alloc_i) alloc_q[free_idx_o] <= 1'b1;
      if (slot.park) valid_q[slot.park_idx] <= 1'b1;
      // Freeing returns the slot to the search
      if (slot.free) begin
        alloc_q[slot.free_idx] <= 1'b0;
        valid_q[slot.free_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slot.park) rsp_q[slot.park_idx] <= slot.park_rsp;
  end

endmodule

// ==== hw/rob_top.sv ====
////////////////////////////////////////////////////////////
// Reorder buffer top level with plain ports
// The network must echo the request tag with each response
////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module rob_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Requests from the endpoint
  input  logic              ax_valid_i,
  input  rob_pkg::id_t      ax_id_i,
  input  rob_pkg::dest_t    ax_dest_i,
  output logic              ax_ready_o,
  // Requests towards the network, with their tag
  output logic              ax_valid_o,
  input  logic              ax_ready_i,
  output logic              ax_rob_req_o,
  output rob_pkg::rob_idx_t ax_rob_idx_o,
  // Responses from the network
  input  logic              rsp_valid_i,
  input  rob_pkg::rsp_t     rsp_i,
  input  logic              rsp_rob_req_i,
  input  rob_pkg::rob_idx_t rsp_rob_idx_i,
  output logic              rsp_ready_o,
  // Responses in request order per ID
  output logic              rsp_valid_o,
  output rob_pkg::rsp_t     rsp_o,
  input  logic              rsp_ready_i
);

  logic              has_free;
  rob_pkg::rob_idx_t free_idx;
  logic              alloc;

  rob_status_if status_if ();
  rob_slot_if   slot_if ();

  rob_req_tracker rob_req_tracker_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ax_valid_i   (ax_valid_i),
    .ax_id_i      (ax_id_i),
    .ax_dest_i    (ax_dest_i),
    .ax_ready_i   (ax_ready_i),
    .ax_valid_o   (ax_valid_o),
    .ax_ready_o   (ax_ready_o),
    .ax_rob_req_o (ax_rob_req_o),
    .ax_rob_idx_o (ax_rob_idx_o),
    .has_free_i   (has_free),
    .free_idx_i   (free_idx),
    .alloc_o      (alloc),
    .status       (status_if.tracker)
  );

  rob_slot_store rob_slot_store_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .alloc_i    (alloc),
    .has_free_o (has_free),
    .free_idx_o (free_idx),
    .slot       (slot_if.store)
  );

  rob_rsp_release rob_rsp_release_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rsp_valid_i   (rsp_valid_i),
    .rsp_i         (rsp_i),
    .rsp_rob_req_i (rsp_rob_req_i),
    .rsp_rob_idx_i (rsp_rob_idx_i),
    .rsp_ready_o   (rsp_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .status        (status_if.releaser),
    .slot          (slot_if.releaser)
  );

endmodule

// ==== tb.f ====
hw/rob_pkg.sv
hw/rob_if.sv
hw/rob_id_fifo.sv
hw/rob_req_tracker.sv
hw/rob_slot_store.sv
hw/rob_rsp_release.sv
hw/rob_top.sv
bench/rob_asserts.sv
bench/rob_tb.sv
